/* board_pkg.sv */
// Touch panel and seven-segment definitions shared by the key decoder, the display and the top level
package board_pkg;

	// ==========================================================================
	// Touch panel coordinates
	// ==========================================================================

	localparam int COORD_W = 12;                // ADC coordinate resolution

	typedef logic [COORD_W-1:0] coord_t;        // One axis sample

	typedef struct packed
	{
		coord_t x;                              // Horizontal position
		coord_t y;                              // Vertical position
	} touch_t;

	// ==========================================================================
	// Key strip geometry
	// ==========================================================================

	// Keys live in a strip along the bottom edge of the panel
	localparam coord_t KEY_ROW_Y = 12'd3072;    // Lowest y of the key strip
	localparam int     ZONE_SHIFT = 9;          // Eight slots of 512 along x

	// ==========================================================================
	// Seven-segment display
	// ==========================================================================

	// Segment a in bit 0, segment g in bit 6
	typedef logic [6:0] hex_t;                  // Active low pattern

endpackage

/* game_pkg.sv */
// Game rule constants and types, imported by the decoder, code register, controller, scorer and display
package game_pkg;

	// ==========================================================================
	// Board size and rules
	// ==========================================================================

	localparam int N_PEGS    = 4;               // Columns in a guess row
	localparam int COLOR_W   = 3;               // Bits per colour
	localparam int N_COLORS  = 6;               // Playable colours 0 to 5
	localparam int N_ROUNDS  = 8;               // Guesses before a loss
	localparam int ROUND_W   = 4;               // Holds 0 to N_ROUNDS
	localparam int PEG_CNT_W = 3;               // Holds 0 to N_PEGS

	// ==========================================================================
	// Row and score types
	// ==========================================================================

	typedef logic [COLOR_W-1:0] color_t;

	typedef struct packed
	{
		color_t col3;                           // Rightmost column
		color_t col2;
		color_t col1;
		color_t col0;                           // First column filled
	} guess_t;

	typedef struct packed
	{
		logic [PEG_CNT_W-1:0] black;            // Right colour, right place
		logic [PEG_CNT_W-1:0] white;            // Right colour, wrong place
	} score_t;

	// Key value equals the touch zone slot
	typedef enum logic [2:0]
	{
		KEY_COLOR0, KEY_COLOR1, KEY_COLOR2,
		KEY_COLOR3, KEY_COLOR4, KEY_COLOR5,
		KEY_CLEAR,                              // Empty the row
		KEY_SUBMIT                              // Score the full row
	} key_e;

	typedef struct packed
	{
		logic valid;                            // One cycle per press
		key_e key;
	} press_t;

	typedef enum logic [1:0] {ST_ENTER, ST_WON, ST_LOST, ST_IDLE} game_state_e;

endpackage

/* touch_zone_decoder.sv */
// Maps a strobed touch coordinate onto the key strip and issues a registered one-cycle key press
`timescale 1ns/1ps

module touch_zone_decoder
	import board_pkg::*;
	import game_pkg::*;
(
	input  logic   iCLK_50,                      // 50 MHz system clock
	input  logic   reset,                        // Synchronous, active high
	input  touch_t touch,                        // Coordinate from the panel ADC
	input  logic   new_coord,                    // Coordinate valid strobe
	output press_t press                         // Key press, valid for one cycle
);

	// ==========================================================================
	// Zone lookup
	// ==========================================================================

	coord_t slot;                                // x divided by the zone width
	logic   hit;                                 // Touch lands on a key
	logic   press_valid;
	key_e   press_key;

	// Anything above the strip is the playfield and is dropped
	always_comb
	begin
		slot = touch.x >> ZONE_SHIFT;            // Top bits of x
		hit  = new_coord && (touch.y >= KEY_ROW_Y);
	end

	// ==========================================================================
	// Press register
	// ==========================================================================

	always_ff @(posedge iCLK_50)
	begin
		if (reset)
		begin
			press_valid <= 1'b0;
		end
		else
		begin
			press_valid <= hit;                  // Strobe lasts one cycle
		end
	end

	// Key code only matters while press_valid is high
	always_ff @(posedge iCLK_50)
	begin
		if (hit)
		begin
			press_key <= key_e'(slot[$bits(key_e)-1:0]); // Slot number is the key
		end
	end

	assign press.valid = press_valid;
	assign press.key   = press_key;

endmodule

/* code_register.sv */
// Holds the secret code taken from the switches and flags the start of a new game
`timescale 1ns/1ps

module code_register
	import game_pkg::*;
(
	input  logic   iCLK_50,                      // 50 MHz system clock
	input  logic   reset,                        // Synchronous, active high
	input  guess_t sw_code,                      // Raw switch colours
	input  logic   load_code,                    // Capture request
	output guess_t code,                         // Secret code for the scorer
	output logic   code_loaded                   // One cycle after capture
);

	// Switch values 6 and 7 have no colour and fall back to colour 0
	function automatic color_t clamp(input color_t c);
		return (c < color_t'(N_COLORS)) ? c : '0;
	endfunction

	always_ff @(posedge iCLK_50)
	begin
		if (reset)
		begin
			code        <= '0;
			code_loaded <= 1'b0;
		end
		else
		begin
			code_loaded <= load_code;            // Tells the controller to restart
			if (load_code)
			begin
				code.col0 <= clamp(sw_code.col0);
				code.col1 <= clamp(sw_code.col1);
				code.col2 <= clamp(sw_code.col2);
				code.col3 <= clamp(sw_code.col3);
			end
		end
	end

endmodule

/* peg_scorer.sv */
// Combinational black and white peg count of the guess row against the secret code
`timescale 1ns/1ps

module peg_scorer
	import game_pkg::*;
(
	input  guess_t guess,                        // Row from the controller
	input  guess_t code,                         // Secret code
	output score_t live_score                    // Valid whenever the row is full
);

	logic [PEG_CNT_W-1:0] black_cnt;             // Exact position matches
	logic [PEG_CNT_W-1:0] match_cnt;             // Colour matches in any place

	always_comb
	begin : count
		color_t               g_col [N_PEGS];
		color_t               c_col [N_PEGS];
		logic [PEG_CNT_W-1:0] g_cnt;             // Uses of one colour in guess
		logic [PEG_CNT_W-1:0] c_cnt;             // Uses of one colour in code

		g_col = '{guess.col0, guess.col1, guess.col2, guess.col3};
		c_col = '{code.col0, code.col1, code.col2, code.col3};

		black_cnt = '0;
		for (int i = 0; i < N_PEGS; i++)
		begin
			if (g_col[i] == c_col[i])
				black_cnt = black_cnt + 1'b1;
		end

		// Per colour the smaller occurrence count is the number of hits
		match_cnt = '0;
		for (int c = 0; c < N_COLORS; c++)
		begin
			g_cnt = '0;
			c_cnt = '0;
			for (int i = 0; i < N_PEGS; i++)
			begin
				if (g_col[i] == color_t'(c))
					g_cnt = g_cnt + 1'b1;
				if (c_col[i] == color_t'(c))
					c_cnt = c_cnt + 1'b1;
			end
			match_cnt = match_cnt + ((g_cnt < c_cnt) ? g_cnt : c_cnt);
		end
	end

	assign live_score.black = black_cnt;
	assign live_score.white = match_cnt - black_cnt; // Black pegs are in match_cnt too

endmodule

/* seg7_display.sv */
// Registered active-low seven-segment decode of the white, black and round counts
`timescale 1ns/1ps

module seg7_display
	import board_pkg::*;
	import game_pkg::*;
(
	input  logic               iCLK_50,          // 50 MHz system clock
	input  logic               reset,            // Synchronous, active high
	input  logic [ROUND_W-1:0] round,            // Rows played
	input  score_t             score,            // Last scored row
	output hex_t               hex0,             // White pegs
	output hex_t               hex1,             // Black pegs
	output hex_t               hex2              // Round number
);

	// Hex digit to segments, a in bit 0, low lights a segment
	function automatic hex_t seg_decode(input logic [3:0] val);
		case (val)
			4'h0:    return 7'h40;
			4'h1:    return 7'h79;
			4'h2:    return 7'h24;
			4'h3:    return 7'h30;
			4'h4:    return 7'h19;
			4'h5:    return 7'h12;
			4'h6:    return 7'h02;
			4'h7:    return 7'h78;
			4'h8:    return 7'h00;
			4'h9:    return 7'h10;
			4'hA:    return 7'h08;
			4'hB:    return 7'h03;
			4'hC:    return 7'h46;
			4'hD:    return 7'h21;
			4'hE:    return 7'h06;
			default: return 7'h0E;               // F
		endcase
	endfunction

	always_ff @(posedge iCLK_50)
	begin
		if (reset)
		begin
			hex0 <= '1;                          // Blank
			hex1 <= '1;
			hex2 <= '1;
		end
		else
		begin
			hex0 <= seg_decode(4'(score.white));
			hex1 <= seg_decode(4'(score.black));
			hex2 <= seg_decode(4'(round));
		end
	end

endmodule

/* game_controller.sv */
// Game state machine handling guess entry, clear and submit, round counting and win or loss
`timescale 1ns/1ps

module game_controller
	import game_pkg::*;
(
	input  logic               iCLK_50,          // 50 MHz system clock
	input  logic               reset,            // Synchronous, active high
	input  press_t             press,            // Decoded key press
	input  logic               code_loaded,      // New game pulse
	input  score_t             live_score,       // Score of the current row
	output guess_t             guess,            // Row under entry
	output score_t             score,            // Score of the last submit
	output logic [ROUND_W-1:0] round,            // Rows submitted
	output logic               next_round,       // One cycle per submit
	output game_state_e        state
);

	// ==========================================================================
	// Row helpers
	// ==========================================================================

	logic [PEG_CNT_W-1:0] fill_cnt;              // Columns already filled
	logic                 take_press;            // Press accepted this cycle
	logic                 row_full;
	logic                 last_round;            // Submit ends the game
	logic                 won;                   // Row matches the code

	// Writes colour c into column idx of the row
	function automatic guess_t fill_col(
		input guess_t               row,
		input logic [PEG_CNT_W-1:0] idx,
		input color_t               c
	);
		guess_t r;
		r = row;
		case (idx)
			0:       r.col0 = c;
			1:       r.col1 = c;
			2:       r.col2 = c;
			default: r.col3 = c;
		endcase
		return r;
	endfunction

	always_comb
	begin
		take_press = press.valid && (state == ST_ENTER); // Ignored once game is over
		row_full   = (fill_cnt == PEG_CNT_W'(N_PEGS));
		last_round = (round == ROUND_W'(N_ROUNDS - 1));
		won        = (live_score.black == PEG_CNT_W'(N_PEGS));
	end

	// ==========================================================================
	// Game FSM
	// ==========================================================================

	always_ff @(posedge iCLK_50)
	begin
		if (reset)
		begin
			guess      <= '0;
			fill_cnt   <= '0;
			score      <= '0;
			round      <= '0;
			next_round <= 1'b0;
			state      <= ST_IDLE;               // Waits for a code
		end
		else
		begin
			next_round <= 1'b0;                  // Pulse by default off
			if (code_loaded)
			begin
				// Fresh game wipes everything from the last one
				guess    <= '0;
				fill_cnt <= '0;
				score    <= '0;
				round    <= '0;
				state    <= ST_ENTER;
			end
			else if (take_press)
			begin
				case (press.key)
					KEY_CLEAR:
					begin
						guess    <= '0;
						fill_cnt <= '0;
					end
					KEY_SUBMIT:
					begin
						if (row_full)            // Partial rows are not scored
						begin
							score      <= live_score;
							round      <= round + 1'b1;
							next_round <= 1'b1;
							guess      <= '0;
							fill_cnt   <= '0;
							if (won)
								state <= ST_WON;
							else if (last_round)
								state <= ST_LOST;
						end
					end
					default:
					begin
						if (!row_full)           // Surplus colours dropped
						begin
							guess    <= fill_col(guess, fill_cnt, color_t'(press.key));
							fill_cnt <= fill_cnt + 1'b1;
						end
					end
				endcase
			end
		end
	end

endmodule

/* mastermind_top.sv */
// Game top level connecting touch decoder, secret code register, controller, peg scorer and display
`timescale 1ns/1ps

module mastermind_top
	import board_pkg::*;
	import game_pkg::*;
(
	input  logic               iCLK_50,          // 50 MHz system clock
	input  logic               reset,            // Synchronous, active high
	input  touch_t             touch,            // Panel coordinate pair
	input  logic               new_coord,        // Coordinate strobe
	input  guess_t             sw_code,          // Secret code switches
	input  logic               load_code,        // Start a new game
	output guess_t             guess,            // Row under entry
	output score_t             score,            // Last scored row
	output logic               next_round,       // Row scored pulse
	output logic [ROUND_W-1:0] round,            // Rows played
	output game_state_e        state,
	output hex_t               hex0,             // White pegs
	output hex_t               hex1,             // Black pegs
	output hex_t               hex2              // Round number
);

	press_t press;                               // Decoded key press
	guess_t code;                                // Secret code after clamp
	logic   code_loaded;                         // New game pulse
	score_t live_score;                          // Score of the current row

	touch_zone_decoder u_decoder (
		.iCLK_50    (iCLK_50),
		.reset      (reset),
		.touch      (touch),
		.new_coord  (new_coord),
		.press      (press)
	);

	code_register u_code (
		.iCLK_50     (iCLK_50),
		.reset       (reset),
		.sw_code     (sw_code),
		.load_code   (load_code),
		.code        (code),
		.code_loaded (code_loaded)
	);

	game_controller u_ctrl (
		.iCLK_50     (iCLK_50),
		.reset       (reset),
		.press       (press),
		.code_loaded (code_loaded),
		.live_score  (live_score),
		.guess       (guess),
		.score       (score),
		.round       (round),
		.next_round  (next_round),
		.state       (state)
	);

	peg_scorer u_scorer (
		.guess      (guess),
		.code       (code),
		.live_score (live_score)
	);

	seg7_display u_display (
		.iCLK_50 (iCLK_50),
		.reset   (reset),
		.round   (round),
		.score   (score),
		.hex0    (hex0),
		.hex1    (hex1),
		.hex2    (hex2)
	);

endmodule

/* mastermind_checker.sv */
// Concurrent assertions on the game top level outputs, attached to the top level by bind
`timescale 1ns/1ps

module mastermind_checker
	import game_pkg::*;
(
	input logic        iCLK_50,                      // System clock
	input logic        reset,
	input logic        next_round,                   // Row scored pulse
	input score_t      score,
	input game_state_e state
);

	// Scored row pulse lasts one cycle
	a_single_pulse: assert property (@(posedge iCLK_50) disable iff (reset)
		next_round |=> !next_round)
		else $error("next_round high on two consecutive cycles");

	// Never more pegs than columns
	a_peg_sum: assert property (@(posedge iCLK_50) disable iff (reset)
		({1'b0, score.black} + {1'b0, score.white}) <= 4'(N_PEGS))
		else $error("black plus white exceeds the column count");

	a_reset_quiet: assert property (@(posedge iCLK_50)
		reset |=> !next_round)
		else $error("next_round high right after reset");

	// A win needs every peg black
	a_win_black: assert property (@(posedge iCLK_50) disable iff (reset)
		(state == ST_WON) |-> (score.black == PEG_CNT_W'(N_PEGS)))
		else $error("won state without a full black score");

endmodule

bind mastermind_top mastermind_checker u_checker (
	.iCLK_50    (iCLK_50),
	.reset      (reset),
	.next_round (next_round),
	.score      (score),
	.state      (state)
);

/* tb_mastermind.sv */
// Self-checking testbench that plays seeded random games on the top level against a rule model
`timescale 1ns/1ps

module tb_mastermind
	import board_pkg::*;
	import game_pkg::*;
();

	localparam int N_GAMES     = 30;
	localparam int MAX_PRESSES = 60;                 // Press slots per game including the load
	localparam int CYCLE_LIMIT = N_GAMES * MAX_PRESSES * 4 + 100;

	logic               iCLK_50 = 1'b0;
	logic               reset;
	touch_t             touch;
	logic               new_coord;
	guess_t             sw_code;
	logic               load_code;
	guess_t             guess;
	score_t             score;
	logic               next_round;
	logic [ROUND_W-1:0] round;
	game_state_e        state;
	hex_t               hex0;
	hex_t               hex1;
	hex_t               hex2;

	integer      seed;
	int          cycle_cnt = 0;
	hex_t        seg_table [10];                     // Active low digits 0 to 9
	guess_t      m_code;                             // Model of the clamped secret code
	guess_t      m_row;
	int          m_fill;
	int          m_round;
	score_t      m_score;
	game_state_e m_state;

	mastermind_top uut (
		.iCLK_50    (iCLK_50),
		.reset      (reset),
		.touch      (touch),
		.new_coord  (new_coord),
		.sw_code    (sw_code),
		.load_code  (load_code),
		.guess      (guess),
		.score      (score),
		.next_round (next_round),
		.round      (round),
		.state      (state),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2)
	);

	always #20 iCLK_50 = ~iCLK_50;                   // 40 ns period

	always @(posedge iCLK_50)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("Run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$fatal(1, "Timeout");
		end
	end

	// ========================================================================
	// Reference model
	// ========================================================================

	function automatic int rand_below(input int n);
		int v;
		v = $random(seed);
		return (v & 32'h7FFF_FFFF) % n;
	endfunction

	function automatic guess_t put_color(input guess_t row, input int idx, input color_t c);
		logic [N_PEGS*COLOR_W-1:0] bits;
		bits = row;
		bits[idx*COLOR_W +: COLOR_W] = c;                // col0 sits in the low bits
		return guess_t'(bits);
	endfunction

	function automatic color_t get_color(input guess_t row, input int idx);
		logic [N_PEGS*COLOR_W-1:0] bits;
		bits = row;
		return bits[idx*COLOR_W +: COLOR_W];
	endfunction

	// Exact matches first, then each leftover guess peg claims one unused code peg
	function automatic score_t score_ref(input guess_t g, input guess_t c);
		logic   used [N_PEGS];
		logic   found;
		int     b;
		int     w;
		score_t s;
		b = 0;
		w = 0;
		for (int i = 0; i < N_PEGS; i++)
		begin
			used[i] = (get_color(g, i) == get_color(c, i));
			if (used[i])
				b++;
		end
		for (int i = 0; i < N_PEGS; i++)
		begin
			found = (get_color(g, i) == get_color(c, i));    // Already black
			for (int j = 0; j < N_PEGS; j++)
			begin
				if (!found && !used[j] && get_color(c, j) == get_color(g, i))
				begin
					used[j] = 1'b1;
					found   = 1'b1;
					w++;
				end
			end
		end
		s.black = PEG_CNT_W'(b);
		s.white = PEG_CNT_W'(w);
		return s;
	endfunction

	// ========================================================================
	// Checks
	// ========================================================================

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic check_outputs();
		check_value("guess", 32'(guess), 32'(m_row));
		check_value("round", 32'(round), 32'(m_round));
		check_value("score", 32'(score), 32'(m_score));
		check_value("state", 32'(state), 32'(m_state));
	endtask

	task automatic check_hex();
		check_value("hex0", 32'(hex0), 32'(seg_table[m_score.white]));
		check_value("hex1", 32'(hex1), 32'(seg_table[m_score.black]));
		check_value("hex2", 32'(hex2), 32'(seg_table[m_round]));
	endtask

	// ========================================================================
	// Stimulus entered and left on a falling edge with four cycles per press
	// ========================================================================

	task automatic press_key(input key_e k, input logic on_strip);
		touch_t t;
		logic   submitted;
		t.x = {k, 9'(rand_below(512))};                  // Slot of the key
		t.y = on_strip ? KEY_ROW_Y + coord_t'(rand_below(1024)) : coord_t'(rand_below(3072));
		submitted = 1'b0;
		if (on_strip && m_state == ST_ENTER)
		begin
			if (k == KEY_CLEAR)
			begin
				m_row  = '0;
				m_fill = 0;
			end
			else if (k == KEY_SUBMIT && m_fill == N_PEGS)
			begin
				submitted = 1'b1;
				m_score   = score_ref(m_row, m_code);
				m_round++;
				m_row     = '0;
				m_fill    = 0;
				if (m_score.black == N_PEGS)
					m_state = ST_WON;
				else if (m_round == N_ROUNDS)
					m_state = ST_LOST;
			end
			else if (k != KEY_SUBMIT && m_fill < N_PEGS)
			begin
				m_row = put_color(m_row, m_fill, color_t'(k));
				m_fill++;
			end
		end
		touch     = t;
		new_coord = 1'b1;
		@(negedge iCLK_50);
		new_coord = 1'b0;
		check_value("next_round", 32'(next_round), 32'(0));
		@(negedge iCLK_50);                              // Controller has acted
		check_value("next_round", 32'(next_round), 32'(submitted));
		check_outputs();
		@(negedge iCLK_50);                              // Display has followed
		check_value("next_round", 32'(next_round), 32'(0));
		check_hex();
		@(negedge iCLK_50);
	endtask

	task automatic load_new_code();
		guess_t sw;
		color_t c;
		sw        = guess_t'(12'(rand_below(4096)));     // Includes the unused values 6 and 7
		sw_code   = sw;
		load_code = 1'b1;
		for (int i = 0; i < N_PEGS; i++)
		begin
			c      = get_color(sw, i);
			m_code = put_color(m_code, i, (c >= N_COLORS) ? 3'd0 : c);
		end
		m_row   = '0;
		m_fill  = 0;
		m_round = 0;
		m_score = '0;
		m_state = ST_ENTER;
		@(negedge iCLK_50);
		load_code = 1'b0;
		@(negedge iCLK_50);
		check_outputs();
		@(negedge iCLK_50);
		check_hex();
		@(negedge iCLK_50);
	endtask

	// From its win round on the player copies the code so a win round of 8 or more is a loss
	task automatic play_game();
		int   n;
		int   r;
		int   win_round;
		key_e k;
		load_new_code();
		win_round = rand_below(11);
		n = 0;
		while (m_state == ST_ENTER && n < MAX_PRESSES - 4)
		begin
			r = rand_below(32);
			if (r == 1)
				k = KEY_CLEAR;
			else if (r == 2 || (m_fill == N_PEGS && r < 26))
				k = KEY_SUBMIT;                          // Partial rows too
			else if (m_round >= win_round)
				k = key_e'(get_color(m_code, m_fill % N_PEGS));
			else
				k = key_e'(3'(rand_below(N_COLORS)));
			press_key(k, r != 0);                        // r of 0 touches the playfield
			n++;
		end
		press_key(KEY_COLOR2, 1'b1);                     // Ignored once the game is over
		press_key(KEY_SUBMIT, 1'b1);
	endtask

	initial
	begin
		seed      = 33265;
		seg_table = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78, 7'h00, 7'h10};
		reset     = 1'b1;
		touch     = '0;
		new_coord = 1'b0;
		sw_code   = '0;
		load_code = 1'b0;
		m_code    = '0;
		m_row     = '0;
		m_fill    = 0;
		m_round   = 0;
		m_score   = '0;
		m_state   = ST_IDLE;
		repeat (2) @(posedge iCLK_50);
		@(negedge iCLK_50);
		reset = 1'b0;
		check_value("next_round", 32'(next_round), 32'(0));
		check_outputs();
		check_value("hex0", 32'(hex0), 32'(7'h7F));     // Blank after reset
		check_value("hex1", 32'(hex1), 32'(7'h7F));
		check_value("hex2", 32'(hex2), 32'(7'h7F));
		press_key(KEY_COLOR1, 1'b1);                     // No game yet
		for (int g = 0; g < N_GAMES; g++)
			play_game();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* sources.f */
board_pkg.sv
game_pkg.sv
touch_zone_decoder.sv
code_register.sv
peg_scorer.sv
seg7_display.sv
game_controller.sv
mastermind_top.sv
mastermind_checker.sv
tb_mastermind.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_mastermind -o tb_mastermind
out=$(./obj_dir/tb_mastermind 2>&1) || true
echo "$out"
if grep -q "TESTBENCH PASSED" <<< "$out"; then
	exit 0
else
	exit 1
fi
